// ==== verilog/qspi_pkg.sv ====
/*
 * Shared types and constants for the APB to quad-SPI memory port.
 * Imported by wildcard into the RTL modules and the testbench.
 */
package qspi_pkg;

	// width code from paddr[25:24]
	typedef enum logic [1:0] {
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2,
		size_bad  = 2'd3
	} access_size_e;

	typedef logic [31:0] word_t;
	typedef logic [23:0] mem_addr_t;

	localparam logic [7:0] CMD_FAST_READ_QUAD = 8'hEB;
	localparam logic [7:0] CMD_QUAD_WRITE     = 8'h38;

	// sck periods between last address nibble and first read nibble
	localparam int DUMMY_SCK = 6;

	function automatic int unsigned size_bytes(access_size_e size);
		case (size)
			size_byte: return 1;
			size_half: return 2;
			size_word: return 4;
			default:   return 0;
		endcase
	endfunction

endpackage

// ==== verilog/qspi_req_if.sv ====
/*
 * Request and completion signals between the APB decoder, the quad-SPI
 * engine and the read result stage. One request is in flight at a time.
 */
`timescale 1ns/1ps

interface qspi_req_if import qspi_pkg::*; ();

	logic         req;
	logic         write;
	access_size_e size;
	mem_addr_t    addr;
	word_t        wdata;
	logic         err;
	logic         done;
	word_t        rdata_raw;

	modport decode (output req, write, size, addr, wdata, err);

	modport engine (input req, write, size, addr, wdata, output done, rdata_raw);

	modport result (input write, size, err, done, rdata_raw);

endinterface

// ==== verilog/apb_decode.sv ====
/*
 * APB slave front end. Splits paddr into byte address and access width,
 * latches the transfer and starts one engine request per APB transfer,
 * or flags a bad width code straight to the result stage.
 */
`timescale 1ns/1ps

module apb_decode import qspi_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [25:0] paddr,
	input  word_t       pwdata,
	input  logic        pready,
	qspi_req_if.decode  bus
);

	logic         busy;
	logic         start;
	access_size_e size_in;

	assign size_in = access_size_e'(paddr[25:24]);

	// first access cycle of a transfer not yet taken
	assign start = psel & penable & ~busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			bus.req <= 1'b0;
			bus.err <= 1'b0;
		end else begin
			bus.req <= start & (size_in != size_bad);
			bus.err <= start & (size_in == size_bad);
			if (start)
				busy <= 1'b1;
			else if (pready)
				busy <= 1'b0;
		end
	end

	// held until the engine reports done
	always_ff @(posedge clk) begin
		if (start) begin
			bus.write <= pwrite;
			bus.size  <= size_in;
			bus.addr  <= paddr[23:0];
			bus.wdata <= pwdata;
		end
	end

endmodule

// ==== verilog/qspi_engine.sv ====
/*
 * Quad-SPI transaction engine. Runs fast-read-quad (0xEB) and quad-write
 * (0x38) with a free running SCK that idles high. State and driven nibbles
 * change on the falling SCK edge, read nibbles are sampled on the rising
 * edge as seen through a three-flop input synchronizer.
 */
`timescale 1ns/1ps

module qspi_engine import qspi_pkg::*; #(
	parameter int SCK_HALF = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	qspi_req_if.engine bus,
	output logic       sck,
	output logic       ce_n,
	inout  wire  [3:0] sio
);

	localparam int DIV_W = $clog2(SCK_HALF);

	typedef enum logic [2:0] {
		st_idle,
		st_cmd,
		st_addr,
		st_dummy,
		st_rdata,
		st_wdata
	} state_e;

	state_e           state;
	logic [DIV_W-1:0] div_cnt;
	logic             half_tick;
	logic             sck_fall;
	logic             sck_rise;
	logic             pending;
	logic             start;
	logic [3:0]       cnt;
	logic [3:0]       nib_last;
	logic [3:0]       rx_left;
	logic [7:0]       cmd_sr;
	mem_addr_t        addr_sr;
	word_t            tx_sr;
	logic             sio_oe;
	logic [3:0]       sio_out;
	logic [3:0]       sio_meta;
	logic [3:0]       sio_mid;
	logic [3:0]       sio_sync;
	logic [2:0]       rd_pipe;

	// sck divider
	assign half_tick = (div_cnt == DIV_W'(SCK_HALF - 1));
	assign sck_fall  = half_tick & sck;
	assign sck_rise  = half_tick & ~sck;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			sck     <= 1'b1;
		end else if (half_tick) begin
			div_cnt <= '0;
			sck     <= ~sck;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign start    = sck_fall & pending & (state == st_idle);
	assign nib_last = 4'(2 * size_bytes(bus.size) - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pending <= 1'b0;
		else if (bus.req)
			pending <= 1'b1;
		else if (start)
			pending <= 1'b0;
	end

	// one shared down-counter, reloaded at each phase change
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			cnt   <= '0;
		end else if (sck_fall) begin
			case (state)
				st_idle: if (pending) begin
					state <= st_cmd;
					cnt   <= 4'd7;
				end
				st_cmd: if (cnt == '0) begin
					state <= st_addr;
					cnt   <= 4'd5;
				end else cnt <= cnt - 1'b1;
				st_addr: if (cnt == '0) begin
					state <= bus.write ? st_wdata : st_dummy;
					cnt   <= bus.write ? nib_last : 4'(DUMMY_SCK - 1);
				end else cnt <= cnt - 1'b1;
				st_dummy: if (cnt == '0) begin
					state <= st_rdata;
					cnt   <= nib_last;
				end else cnt <= cnt - 1'b1;
				st_rdata, st_wdata: if (cnt == '0)
					state <= st_idle;
				else cnt <= cnt - 1'b1;
				default: state <= st_idle;
			endcase
		end
	end

	// outgoing shifters, bytes go high nibble first from byte 0
	always_ff @(posedge clk) begin
		if (start) begin
			cmd_sr  <= bus.write ? CMD_QUAD_WRITE : CMD_FAST_READ_QUAD;
			addr_sr <= bus.addr;
			tx_sr   <= bus.wdata;
		end else if (sck_fall) begin
			if (state == st_cmd)
				cmd_sr <= {cmd_sr[6:0], 1'b0};
			if (state == st_addr)
				addr_sr <= {addr_sr[19:0], 4'h0};
			if (state == st_wdata && !cnt[0])
				tx_sr <= tx_sr >> 8;
		end
	end

	always_comb begin
		sio_oe  = 1'b1;
		sio_out = 4'h0;
		case (state)
			st_cmd:   sio_out = {3'b000, cmd_sr[7]};
			st_addr:  sio_out = addr_sr[23:20];
			st_wdata: sio_out = cnt[0] ? tx_sr[7:4] : tx_sr[3:0];
			default:  sio_oe = 1'b0;
		endcase
	end

	assign sio = sio_oe ? sio_out : 4'bz;

	// low together with the first command bit, high a clk after idle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ce_n <= 1'b1;
		else
			ce_n <= ~(start | (state != st_idle));
	end

	// rise marks travel alongside the data synchronizer
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sio_meta <= '0;
			sio_mid  <= '0;
			sio_sync <= '0;
			rd_pipe  <= '0;
		end else begin
			sio_meta <= sio;
			sio_mid  <= sio_meta;
			sio_sync <= sio_mid;
			rd_pipe  <= {rd_pipe[1:0], sck_rise & (state == st_rdata)};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_left  <= '0;
			bus.done <= 1'b0;
		end else begin
			bus.done <= (sck_fall & (state == st_wdata) & (cnt == '0)) |
				(rd_pipe[2] & (rx_left == 4'd1));
			if (sck_fall && state == st_dummy && cnt == '0)
				rx_left <= nib_last + 1'b1;
			else if (rd_pipe[2] && rx_left != '0)
				rx_left <= rx_left - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			bus.rdata_raw <= '0;
		else if (rd_pipe[2])
			bus.rdata_raw <= {bus.rdata_raw[27:0], sio_sync};
	end

endmodule

// ==== verilog/read_align.sv ====
/*
 * Result stage. Reorders received read bytes so the first byte off the
 * bus lands in prdata[7:0], and closes the APB transfer with pready.
 */
`timescale 1ns/1ps

module read_align import qspi_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	qspi_req_if.result bus,
	output word_t      prdata,
	output logic       pready,
	output logic       pslverr
);

	word_t aligned;
	int    nbytes;

	// first received byte sits highest in rdata_raw
	always_comb begin
		nbytes  = int'(size_bytes(bus.size));
		aligned = '0;
		for (int i = 0; i < 4; i++) begin
			if (i < nbytes)
				aligned[8*i +: 8] = bus.rdata_raw[8*(nbytes-1-i) +: 8];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pready  <= 1'b0;
			pslverr <= 1'b0;
		end else begin
			pready  <= bus.done | bus.err;
			pslverr <= bus.err;
		end
	end

	always_ff @(posedge clk) begin
		if (bus.done || bus.err)
			prdata <= (bus.done && !bus.write) ? aligned : '0;
	end

endmodule

// ==== verilog/qspi_apb_top.sv ====
/*
 * APB to quad-SPI memory port. Each APB transfer becomes one serial
 * transaction, with pready held low until it ends.
 */
`timescale 1ns/1ps

module qspi_apb_top import qspi_pkg::*; #(
	parameter int SCK_HALF = 8
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [25:0] paddr,
	input  word_t       pwdata,
	output word_t       prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        sck,
	output logic        ce_n,
	inout  wire  [3:0]  sio
);

	qspi_req_if bus_if ();

	apb_decode u_decode (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pready  (pready),
		.bus     (bus_if.decode)
	);

	qspi_engine #(.SCK_HALF(SCK_HALF)) u_engine (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (bus_if.engine),
		.sck   (sck),
		.ce_n  (ce_n),
		.sio   (sio)
	);

	read_align u_result (
		.clk     (clk),
		.rst_n   (rst_n),
		.bus     (bus_if.result),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

endmodule

// ==== dv/qspi_mem_model.sv ====
/*
 * Behavioural quad-SPI memory for simulation. Answers fast-read-quad and
 * quad-write on a 16 MB byte space; bytes never written follow a fill pattern.
 */
`timescale 1ns/1ps

module qspi_mem_model import qspi_pkg::*; (
	input  logic      sck,
	input  logic      ce_n,
	inout  wire [3:0] sio
);

	logic [7:0] mem [mem_addr_t];
	int         edges;
	int         nib_idx;
	logic [7:0] cmd;
	mem_addr_t  addr;
	logic [3:0] hi_nib;
	logic [7:0] rd_byte;
	logic       drive;
	logic [3:0] dout;

	assign sio = drive ? dout : 4'bz;

	function automatic logic [7:0] fill_byte(mem_addr_t a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h3c;
	endfunction

	task automatic clear_state();
		edges   = 0;
		nib_idx = 0;
		cmd     = '0;
		drive   = 1'b0;
	endtask

	initial clear_state();

	// transaction ends when ce_n goes high
	always @(posedge ce_n) clear_state();

	always @(posedge sck) begin
		if (!ce_n) begin
			edges++;
			if (edges <= 8)
				cmd = {cmd[6:0], sio[0]};
			else if (edges <= 14)
				addr = {addr[19:0], sio};
			else if (cmd == CMD_QUAD_WRITE) begin
				if (!nib_idx[0])
					hi_nib = sio;
				else begin
					mem[addr] = {hi_nib, sio};
					addr = addr + 1'b1;
				end
				nib_idx++;
			end
		end
	end

	// first nibble goes out on the fall that ends the dummy phase
	always @(negedge sck) begin
		if (!ce_n && cmd == CMD_FAST_READ_QUAD && edges >= 14 + DUMMY_SCK) begin
			rd_byte = mem.exists(addr) ? mem[addr] : fill_byte(addr);
			dout  = nib_idx[0] ? rd_byte[3:0] : rd_byte[7:4];
			drive = 1'b1;
			if (nib_idx[0])
				addr = addr + 1'b1;
			nib_idx++;
		end
	end

endmodule

// ==== dv/qspi_props.sv ====
/*
 * Pin and APB protocol assertions, bound into the quad-SPI top level.
 */
`timescale 1ns/1ps

module qspi_props (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic ce_n,
	input logic sio_oe
);

	int fail_count = 0;

	// no sio drive outside a chip select window
	assert property (@(posedge clk) disable iff (!rst_n) ce_n |-> !sio_oe)
		else begin
			fail_count++;
			$error("sio output enable set while ce_n is high");
		end

	assert property (@(posedge clk) disable iff (!rst_n) pready |-> psel && penable)
		else begin
			fail_count++;
			$error("pready high outside an APB access phase");
		end

	// at least one full clk of deselect between transactions
	assert property (@(posedge clk) disable iff (!rst_n) $rose(ce_n) |=> ce_n)
		else begin
			fail_count++;
			$error("ce_n high for less than one clk between transactions");
		end

endmodule

bind qspi_apb_top qspi_props u_props (
	.clk     (clk),
	.rst_n   (rst_n),
	.psel    (psel),
	.penable (penable),
	.pready  (pready),
	.ce_n    (ce_n),
	.sio_oe  (u_engine.sio_oe)
);

// ==== dv/tb_qspi_apb.sv ====
/*
 * Testbench for the APB to quad-SPI memory port. Runs a table of APB
 * transfers against a behavioural serial memory and checks results
 * against a byte mirror of the memory kept here.
 */
`timescale 1ns/1ps

module tb_qspi_apb import qspi_pkg::*; ();

	localparam int SCK_HALF = 2;

	typedef struct {
		string        name;
		logic         write;
		access_size_e size;
		mem_addr_t    addr;
		word_t        wdata;
		word_t        exp_rdata;
		logic         exp_err;
	} xfer_t;

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [25:0] paddr;
	word_t       pwdata;
	word_t       prdata;
	logic        pready;
	logic        pslverr;
	logic        sck;
	logic        ce_n;
	wire  [3:0]  sio;

	xfer_t       table_q[$];
	logic [7:0]  mirror [mem_addr_t];
	int          data_errors = 0;
	int          flag_errors = 0;
	int unsigned cycles = 0;
	int unsigned cycle_limit = 0;
	string       cur_name = "reset";

	qspi_apb_top #(.SCK_HALF(SCK_HALF)) uut (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.sck     (sck),
		.ce_n    (ce_n),
		.sio     (sio)
	);

	qspi_mem_model mem (
		.sck  (sck),
		.ce_n (ce_n),
		.sio  (sio)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// unwritten bytes of the serial memory
	function automatic logic [7:0] fill_byte(mem_addr_t a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h3c;
	endfunction

	function automatic logic [7:0] mirror_byte(mem_addr_t a);
		return mirror.exists(a) ? mirror[a] : fill_byte(a);
	endfunction

	task automatic add_entry(input string name, input logic write, input access_size_e size,
			input mem_addr_t addr, input word_t wdata);
		xfer_t     t;
		int        nbytes;
		mem_addr_t a;
		case (size)
			size_byte: nbytes = 1;
			size_half: nbytes = 2;
			size_word: nbytes = 4;
			default:   nbytes = 0;
		endcase
		t.name      = name;
		t.write     = write;
		t.size      = size;
		t.addr      = addr;
		t.wdata     = wdata;
		t.exp_err   = (size == size_bad);
		t.exp_rdata = '0;
		// bytes go to ascending addresses from byte lane 0
		for (int i = 0; i < nbytes; i++) begin
			a = addr + mem_addr_t'(i);
			if (write)
				mirror[a] = wdata[8*i +: 8];
			else
				t.exp_rdata[8*i +: 8] = mirror_byte(a);
		end
		table_q.push_back(t);
	endtask

	task automatic build_table();
		add_entry("word_wr_100", 1'b1, size_word, 24'h000100, $urandom());
		add_entry("word_rd_100", 1'b0, size_word, 24'h000100, '0);
		add_entry("word_wr_200", 1'b1, size_word, 24'h000200, 32'h4433_2211);
		add_entry("byte_wr_203", 1'b1, size_byte, 24'h000203, 32'hffff_ffa7);
		add_entry("half_wr_201", 1'b1, size_half, 24'h000201, 32'h0000_c35e);
		add_entry("word_rd_200", 1'b0, size_word, 24'h000200, '0);
		add_entry("byte_rd_202", 1'b0, size_byte, 24'h000202, '0);
		add_entry("half_rd_201", 1'b0, size_half, 24'h000201, '0);
		add_entry("byte_rd_fill", 1'b0, size_byte, 24'h3a5c71, '0);
		add_entry("half_rd_102", 1'b0, size_half, 24'h000102, '0);
		add_entry("bad_wr_100", 1'b1, size_bad, 24'h000100, $urandom());
		add_entry("word_rd_100_after_bad", 1'b0, size_word, 24'h000100, '0);
		add_entry("bad_rd_200", 1'b0, size_bad, 24'h000200, '0);
		add_entry("word_wr_top", 1'b1, size_word, 24'hfffffc, $urandom());
		add_entry("byte_wr_top", 1'b1, size_byte, 24'hffffff, $urandom());
		add_entry("word_rd_top", 1'b0, size_word, 24'hfffffc, '0);
		add_entry("byte_rd_top", 1'b0, size_byte, 24'hffffff, '0);
		add_entry("word_rd_fill", 1'b0, size_word, 24'h800000, '0);
	endtask

	task automatic check_data(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			data_errors++;
			$display("Error: %s prdata expected %08h, actual %08h", name, expected, actual);
		end
	endtask

	task automatic check_err(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			flag_errors++;
			$display("Error: %s pslverr expected %0b, actual %0b", name, expected, actual);
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: transfer %s never completed within %0d clock cycles",
				cur_name, cycle_limit);
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(37422));
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		build_table();
		cycle_limit = table_q.size() * 40 * 2 * (SCK_HALF + 1);
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		// transfers run back to back, next setup on the completing edge
		foreach (table_q[i]) begin
			cur_name = table_q[i].name;
			psel    <= 1'b1;
			penable <= 1'b0;
			pwrite  <= table_q[i].write;
			paddr   <= {table_q[i].size, table_q[i].addr};
			pwdata  <= table_q[i].wdata;
			@(posedge clk);
			penable <= 1'b1;
			@(posedge clk);
			while (!pready)
				@(posedge clk);
			check_err(table_q[i].name, table_q[i].exp_err, pslverr);
			if (!table_q[i].write || table_q[i].exp_err)
				check_data(table_q[i].name, table_q[i].exp_rdata, prdata);
		end
		psel    <= 1'b0;
		penable <= 1'b0;
		repeat (4) @(posedge clk);
		$display("errors: prdata %0d, pslverr %0d, assertions %0d",
			data_errors, flag_errors, uut.u_props.fail_count);
		if (data_errors + flag_errors + uut.u_props.fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== sources.f ====
verilog/qspi_pkg.sv
verilog/qspi_req_if.sv
verilog/apb_decode.sv
verilog/qspi_engine.sv
verilog/read_align.sv
verilog/qspi_apb_top.sv
dv/qspi_mem_model.sv
dv/qspi_props.sv
dv/tb_qspi_apb.sv

// ==== Bender.yml ====
package:
  name: qspi_apb

sources:
  - verilog/qspi_pkg.sv
  - verilog/qspi_req_if.sv
  - verilog/apb_decode.sv
  - verilog/qspi_engine.sv
  - verilog/read_align.sv
  - verilog/qspi_apb_top.sv
  - target: simulation
    files:
      - dv/qspi_mem_model.sv
      - dv/qspi_props.sv
      - dv/tb_qspi_apb.sv
